//--- tluh_sram_adapter.f
hdl/tluh_pkg.sv
hdl/tluh_req_decode.sv
hdl/tluh_atomic_alu.sv
hdl/tluh_sram_seq.sv
hdl/tluh_rsp_buffer.sv
hdl/tluh_sram_adapter.sv
tb/tb_tluh_sram_adapter.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_tluh_sram_adapter
RTL_TOP   ?= tluh_sram_adapter
FILELIST  ?= tluh_sram_adapter.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

# lint the RTL on its own, then with the testbench on top
lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# the status of the last command in the recipe decides pass or fail
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_tluh_sram_adapter.sv
// ================================================
// tluh SRAM adapter testbench
// table driven A channel traffic against an SRAM
// model with random grant and read latency, checked
// against a reference memory
// ================================================
`timescale 1ns/100ps
`default_nettype none

module tb_tluh_sram_adapter;

  import tluh_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 5;
  localparam int MEM_WORDS  = 2 ** SRAM_AW;
  // reads of this address come back with an uncorrectable error
  localparam tl_addr_t BAD_ADDR = 32'h0000_0b10;

  typedef struct packed {
    logic [2:0] opcode;
    logic [2:0] param;
    tl_size_t   size;
    tl_addr_t   addr;
    tl_mask_t   mask;
    tl_data_t   data;
    logic [3:0] stall;
    logic       exp_err;
  } test_t;

  logic       clk_i;
  logic       rst_ni;
  logic       a_valid_i;
  logic       a_ready_o;
  tl_a_t      a_i;
  logic       d_valid_o;
  logic       d_ready_i;
  tl_d_t      d_o;
  logic       req_o;
  logic       gnt_i;
  logic       we_o;
  sram_addr_t addr_o;
  tl_data_t   wdata_o;
  tl_data_t   wmask_o;
  tl_data_t   rdata_i;
  logic       rvalid_i;
  logic [1:0] rerror_i;

  test_t    tests[$];
  logic     table_ready;
  tl_data_t sram_mem[MEM_WORDS];
  tl_data_t ref_mem[MEM_WORDS];
  logic     req_seen;
  int       gnt_wait;
  int       rd_wait;
  sram_addr_t rd_addr;
  int       fail_count;
  int       tests_failed;

  tluh_sram_adapter uut (
    .clk_i, .rst_ni,
    .a_valid_i, .a_ready_o, .a_i,
    .d_valid_o, .d_ready_i, .d_o,
    .req_o, .gnt_i, .we_o, .addr_o, .wdata_o, .wmask_o,
    .rdata_i, .rvalid_i, .rerror_i
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // SRAM model, grant after 0..3 cycles, read data 1..3 cycles after the grant
  always @(negedge clk_i) begin
    rvalid_i = 1'b0;
    rerror_i = 2'b00;
    gnt_i    = 1'b0;
    if (rd_wait > 0) begin
      rd_wait--;
      if (rd_wait == 0) begin
        rvalid_i = 1'b1;
        rdata_i  = sram_mem[rd_addr];
        rerror_i = (rd_addr == BAD_ADDR[SRAM_AW+1:2]) ? 2'b10 : 2'b00;
      end
    end
    if (rst_ni && req_o) begin
      req_seen = 1'b1;
      if (gnt_wait < 0) begin
        gnt_wait = $urandom_range(3, 0);
      end
      if (gnt_wait == 0) begin
        gnt_i    = 1'b1;
        gnt_wait = -1;
        if (we_o) begin
          sram_mem[addr_o] = (sram_mem[addr_o] & ~wmask_o) | (wdata_o & wmask_o);
        end else begin
          rd_addr = addr_o;
          rd_wait = $urandom_range(3, 1);
        end
      end else begin
        gnt_wait--;
      end
    end
  end

  task automatic add_test(input logic [2:0] opcode, input logic [2:0] param,
                          input tl_size_t size, input tl_addr_t addr, input tl_mask_t mask,
                          input tl_data_t data, input logic [3:0] stall, input logic exp_err);
    tests.push_back({opcode, param, size, addr, mask, data, stall, exp_err});
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error: %s is %h, expected %h", name, got, exp);
      fail_count++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("check failed: %s", what);
      fail_count++;
    end
  endtask

  // requests the adapter must refuse without an SRAM access
  function automatic logic is_unsupported(input logic [2:0] opcode, input logic [2:0] param,
                                          input tl_size_t size);
    return (size == 2'd3) || (opcode > Get) ||
           (opcode == LogicalData && param > LogicSwap) ||
           (opcode == ArithmeticData && param > ArithAdd);
  endfunction

  // byte lanes of new_word replace old_word where mask is set
  function automatic tl_data_t merge_bytes(input tl_data_t old_word, input tl_data_t new_word,
                                           input tl_mask_t mask);
    tl_data_t r;
    r = old_word;
    for (int b = 0; b < TL_DBW; b++) begin
      if (mask[b]) begin
        r[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return r;
  endfunction

  function automatic tl_data_t atomic_calc(input logic [2:0] opcode, input logic [2:0] param,
                                           input tl_data_t mem_word, input tl_data_t operand);
    tl_data_t r;
    r = mem_word;
    if (opcode == LogicalData) begin
      case (param)
        LogicXor:  r = mem_word ^ operand;
        LogicOr:   r = mem_word | operand;
        LogicAnd:  r = mem_word & operand;
        LogicSwap: r = operand;
        default:   r = mem_word;
      endcase
    end else begin
      case (param)
        ArithMin:  r = ($signed(operand) < $signed(mem_word)) ? operand : mem_word;
        ArithMax:  r = ($signed(operand) > $signed(mem_word)) ? operand : mem_word;
        ArithMinu: r = (operand < mem_word) ? operand : mem_word;
        ArithMaxu: r = (operand > mem_word) ? operand : mem_word;
        ArithAdd:  r = mem_word + operand;
        default:   r = mem_word;
      endcase
    end
    return r;
  endfunction

  task automatic run_test(input int idx);
    test_t      t;
    sram_addr_t word;
    tl_data_t   old_word;
    logic       unsup;
    logic [2:0] exp_opcode;
    tl_d_t      held;
    int         fails_before;
    t            = tests[idx];
    fails_before = fail_count;
    unsup        = is_unsupported(t.opcode, t.param, t.size);
    word         = t.addr[SRAM_AW+1:2];
    old_word     = ref_mem[word];
    exp_opcode   = (unsup || t.opcode inside {PutFullData, PutPartialData}) ?
                   AccessAck : AccessAckData;
    // reference memory follows the access rules, errors leave it alone
    if (!unsup && t.addr != BAD_ADDR) begin
      if (t.opcode == PutFullData) begin
        ref_mem[word] = t.data;
      end else if (t.opcode == PutPartialData) begin
        ref_mem[word] = merge_bytes(old_word, t.data, t.mask);
      end else if (t.opcode inside {LogicalData, ArithmeticData}) begin
        ref_mem[word] = merge_bytes(old_word,
                                    atomic_calc(t.opcode, t.param, old_word, t.data), t.mask);
      end
    end
    while (!a_ready_o) @(negedge clk_i);
    req_seen       = 1'b0;
    a_valid_i      = 1'b1;
    a_i.opcode     = t.opcode;
    a_i.param      = t.param;
    a_i.size       = t.size;
    a_i.source     = idx[3:0];
    a_i.address    = t.addr;
    a_i.mask       = t.mask;
    a_i.data       = t.data;
    // A handshake happens on the posedge in between
    @(negedge clk_i);
    a_valid_i = 1'b0;
    if (unsup) begin
      check_true(d_valid_o, "d_valid_o not high one cycle after an error request");
    end
    while (!d_valid_o) @(negedge clk_i);
    held = d_o;
    for (int s = 0; s < int'(t.stall); s++) begin
      @(negedge clk_i);
      check_true(d_valid_o, "d_valid_o dropped while d_ready_i was low");
      check_true(d_o === held, "d_o changed while d_ready_i was low");
      check_true(!a_ready_o, "a_ready_o high while a response waits");
    end
    check_value("d_o.opcode", 32'(d_o.opcode), 32'(exp_opcode));
    check_value("d_o.size", 32'(d_o.size), 32'(t.size));
    check_value("d_o.source", 32'(d_o.source), 32'(idx[3:0]));
    check_value("d_o.error", 32'(d_o.error), 32'(t.exp_err));
    if (exp_opcode == AccessAckData) begin
      check_value("d_o.data", d_o.data, old_word);
    end
    d_ready_i = 1'b1;
    @(negedge clk_i);
    d_ready_i = 1'b0;
    check_true(a_ready_o, "a_ready_o not high in the cycle after the D handshake");
    // stored word after the access, masked writes and atomic results included
    check_value("sram_mem", sram_mem[word], ref_mem[word]);
    if (unsup) begin
      check_true(!req_seen, "SRAM request seen for an unsupported request");
    end
    if (fail_count != fails_before) begin
      tests_failed++;
    end
    $display("test %0d opcode %0d param %0d addr %h: %s", idx, t.opcode, t.param, t.addr,
             (fail_count == fails_before) ? "ok" : "failed");
  endtask

  // ends the run when the table takes far longer than it should
  initial begin
    wait (table_ready);
    repeat (tests.size() * 40 + RST_CYCLES) @(posedge clk_i);
    $display("watchdog timeout, the test table did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(32'hb8d3_530d));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    a_valid_i    = 1'b0;
    a_i          = '0;
    d_ready_i    = 1'b0;
    gnt_i        = 1'b0;
    rdata_i      = '0;
    rvalid_i     = 1'b0;
    rerror_i     = 2'b00;
    req_seen     = 1'b0;
    gnt_wait     = -1;
    rd_wait      = 0;
    rd_addr      = '0;
    fail_count   = 0;
    tests_failed = 0;
    table_ready  = 1'b0;
    // fill pattern carries the full word address twice
    for (int i = 0; i < MEM_WORDS; i++) begin
      sram_mem[i] = {6'h2d, i[9:0], 6'h13, i[9:0]};
      ref_mem[i]  = sram_mem[i];
    end
    //       opcode          param      size  addr           mask  data           stall err
    add_test(PutFullData,    3'd0,      2'd2, 32'h0000_0100, 4'h3, 32'hdead_beef, 4'd0, 1'b0);
    add_test(Get,            3'd0,      2'd2, 32'h0000_0100, 4'hf, 32'h0,         4'd1, 1'b0);
    add_test(PutPartialData, 3'd0,      2'd2, 32'h0000_0104, 4'h5, 32'h1122_3344, 4'd0, 1'b0);
    add_test(Get,            3'd0,      2'd2, 32'h0000_0104, 4'hf, 32'h0,         4'd0, 1'b0);
    add_test(LogicalData,    LogicXor,  2'd2, 32'h0000_0108, 4'hf, 32'hff00_ff00, 4'd0, 1'b0);
    add_test(LogicalData,    LogicOr,   2'd2, 32'h0000_010c, 4'h3, 32'h0f0f_0f0f, 4'd0, 1'b0);
    add_test(LogicalData,    LogicAnd,  2'd2, 32'h0000_0110, 4'hf, 32'h00ff_ff00, 4'd2, 1'b0);
    add_test(LogicalData,    LogicSwap, 2'd2, 32'h0000_0114, 4'hc, 32'hcafe_f00d, 4'd0, 1'b0);
    add_test(ArithmeticData, ArithMin,  2'd2, 32'h0000_0118, 4'hf, 32'h7000_0005, 4'd0, 1'b0);
    add_test(ArithmeticData, ArithMax,  2'd2, 32'h0000_011c, 4'hf, 32'h7000_0000, 4'd1, 1'b0);
    add_test(ArithmeticData, ArithMinu, 2'd2, 32'h0000_0120, 4'hf, 32'h0000_0005, 4'd0, 1'b0);
    add_test(ArithmeticData, ArithMaxu, 2'd2, 32'h0000_0124, 4'hf, 32'h7fff_0000, 4'd0, 1'b0);
    add_test(ArithmeticData, ArithAdd,  2'd2, 32'h0000_0128, 4'h7, 32'h7fff_ffff, 4'd3, 1'b0);
    add_test(Get,            3'd0,      2'd2, 32'h0000_0108, 4'hf, 32'h0,         4'd0, 1'b0);
    add_test(Get,            3'd0,      2'd2, 32'h0000_0114, 4'hf, 32'h0,         4'd0, 1'b0);
    add_test(Get,            3'd0,      2'd1, 32'h0000_0128, 4'h3, 32'h0,         4'd0, 1'b0);
    add_test(3'd6,           3'd0,      2'd2, 32'h0000_0130, 4'hf, 32'h0,         4'd0, 1'b1);
    add_test(Get,            3'd0,      2'd3, 32'h0000_0134, 4'hf, 32'h0,         4'd2, 1'b1);
    add_test(LogicalData,    3'd5,      2'd2, 32'h0000_0138, 4'hf, 32'h1234_5678, 4'd0, 1'b1);
    add_test(Get,            3'd0,      2'd2, BAD_ADDR,      4'hf, 32'h0,         4'd1, 1'b1);
    add_test(Get,            3'd0,      2'd2, 32'h0000_010c, 4'hf, 32'h0,         4'd4, 1'b0);
    table_ready = 1'b1;
    repeat (RST_CYCLES) @(negedge clk_i);
    check_true(!req_o && !we_o && !d_valid_o, "SRAM request or d_valid_o high in reset");
    rst_ni = 1'b1;
    check_true(!a_ready_o, "a_ready_o high in the first cycle after reset");
    @(negedge clk_i);
    check_true(!req_o && !we_o && !d_valid_o, "SRAM request or d_valid_o high after reset");
    for (int i = 0; i < tests.size(); i++) begin
      run_test(i);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d failed checks", tests.size(),
             tests.size() - tests_failed, tests_failed, fail_count);
    if (fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/tluh_sram_adapter.sv
// ================================================
// tluh SRAM adapter
// TileLink-UH A/D channels to a single port SRAM,
// one request in flight at a time
// ================================================
`timescale 1ns/100ps
`default_nettype none

module tluh_sram_adapter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 a_valid_i,
  output logic                 a_ready_o,
  input  tluh_pkg::tl_a_t      a_i,
  output logic                 d_valid_o,
  input  logic                 d_ready_i,
  output tluh_pkg::tl_d_t      d_o,
  output logic                 req_o,
  input  logic                 gnt_i,
  output logic                 we_o,
  output tluh_pkg::sram_addr_t addr_o,
  output tluh_pkg::tl_data_t   wdata_o,
  output tluh_pkg::tl_data_t   wmask_o,
  input  tluh_pkg::tl_data_t   rdata_i,
  input  logic                 rvalid_i,
  input  logic [1:0]           rerror_i
);

  import tluh_pkg::*;

  req_t     req;
  logic     req_valid;
  logic     idle;
  req_op_e  alu_op;
  logic [2:0] alu_func;
  tl_data_t alu_old;
  tl_data_t alu_operand;
  tl_data_t alu_result;
  logic     rsp_valid;
  rsp_t     rsp;
  logic     rsp_done;

  // A handshake, accepted only while the sequencer is idle
  assign req_valid = a_valid_i && idle;
  assign a_ready_o = idle;

  tluh_req_decode u_decode (
    .a_i  (a_i),
    .req_o(req)
  );

  tluh_sram_seq u_seq (
    .clk_i, .rst_ni,
    .req_valid_i(req_valid), .req_i(req), .idle_o(idle),
    .req_o, .gnt_i, .we_o, .addr_o, .wdata_o, .wmask_o,
    .rdata_i, .rvalid_i, .rerror_i,
    .alu_op_o(alu_op), .alu_func_o(alu_func),
    .alu_old_o(alu_old), .alu_operand_o(alu_operand), .alu_result_i(alu_result),
    .rsp_valid_o(rsp_valid), .rsp_o(rsp), .rsp_done_i(rsp_done)
  );

  tluh_atomic_alu u_alu (
    .op_i(alu_op), .func_i(alu_func), .old_i(alu_old),
    .operand_i(alu_operand), .result_o(alu_result)
  );

  tluh_rsp_buffer u_rsp (
    .clk_i, .rst_ni,
    .rsp_valid_i(rsp_valid), .rsp_i(rsp),
    .d_valid_o, .d_ready_i, .d_o, .rsp_done_o(rsp_done)
  );

endmodule

`default_nettype wire

//--- hdl/tluh_rsp_buffer.sv
// ================================================
// tluh response buffer
// holds one response and presents it on the D
// channel until the host takes it
// ================================================
`timescale 1ns/100ps
`default_nettype none

module tluh_rsp_buffer (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            rsp_valid_i,
  input  tluh_pkg::rsp_t  rsp_i,
  output logic            d_valid_o,
  input  logic            d_ready_i,
  output tluh_pkg::tl_d_t d_o,
  output logic            rsp_done_o
);

  import tluh_pkg::*;

  logic full_q;
  rsp_t rsp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (rsp_valid_i) begin
      full_q <= 1'b1;
    end else if (d_ready_i) begin
      // drop on the handshake, ready alone on an empty buffer is harmless
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_valid_i) begin
      rsp_q <= rsp_i;
    end
  end

  assign d_valid_o  = full_q;
  assign rsp_done_o = full_q && d_ready_i;

  // writes and errored requests answer without data
  assign d_o.opcode = rsp_q.has_data ? AccessAckData : AccessAck;
  assign d_o.size   = rsp_q.size;
  assign d_o.source = rsp_q.source;
  assign d_o.error  = rsp_q.error;
  assign d_o.data   = rsp_q.has_data ? rsp_q.data : '0;

  // sequencer waits for rsp_done before it takes the next request
  assert property (@(posedge clk_i) disable iff (!rst_ni) rsp_valid_i |-> !full_q);

endmodule

`default_nettype wire

//--- hdl/tluh_sram_seq.sv
// ================================================
// tluh SRAM sequencer
// runs one request at a time against the SRAM:
// read, write or read-modify-write, then hands one
// response to the buffer and waits for it to drain
// ================================================
`timescale 1ns/100ps
`default_nettype none

module tluh_sram_seq (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  input  tluh_pkg::req_t       req_i,
  output logic                 idle_o,
  output logic                 req_o,
  input  logic                 gnt_i,
  output logic                 we_o,
  output tluh_pkg::sram_addr_t addr_o,
  output tluh_pkg::tl_data_t   wdata_o,
  output tluh_pkg::tl_data_t   wmask_o,
  input  tluh_pkg::tl_data_t   rdata_i,
  input  logic                 rvalid_i,
  input  logic [1:0]           rerror_i,
  output tluh_pkg::req_op_e    alu_op_o,
  output logic [2:0]           alu_func_o,
  output tluh_pkg::tl_data_t   alu_old_o,
  output tluh_pkg::tl_data_t   alu_operand_o,
  input  tluh_pkg::tl_data_t   alu_result_i,
  output logic                 rsp_valid_o,
  output tluh_pkg::rsp_t       rsp_o,
  input  logic                 rsp_done_i
);

  import tluh_pkg::*;

  typedef enum logic [2:0] {
    Idle,
    Read,
    ReadWait,
    Write,
    Respond,
    WaitDone
  } state_e;

  state_e   state_q;
  // low for the first cycle out of reset
  logic     init_q;
  req_t     req_q;
  // read word, also the old word of an atomic
  tl_data_t old_q;
  logic     err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      init_q  <= 1'b0;
    end else begin
      init_q <= 1'b1;
      case (state_q)
        Idle: begin
          if (req_valid_i) begin
            case (req_i.op)
              OpWrite: state_q <= Write;
              // error was strobed out already, just wait for the D handshake
              OpError: state_q <= WaitDone;
              default: state_q <= Read;
            endcase
          end
        end
        Read:     if (gnt_i) state_q <= ReadWait;
        // atomic goes on to the write unless the read was bad
        ReadWait: begin
          if (rvalid_i) begin
            state_q <= (rerror_i[1] || req_q.op == OpRead) ? Respond : Write;
          end
        end
        Write:    if (gnt_i) state_q <= Respond;
        Respond:  state_q <= WaitDone;
        WaitDone: if (rsp_done_i) state_q <= Idle;
        default:  state_q <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == Idle && req_valid_i) begin
      req_q <= req_i;
      err_q <= 1'b0;
    end
    // only the uncorrectable bit matters here
    if (state_q == ReadWait && rvalid_i) begin
      old_q <= rdata_i;
      err_q <= rerror_i[1];
    end
  end

  assign idle_o = (state_q == Idle) && init_q;

  // SRAM request straight from registers, stable until grant
  assign req_o   = (state_q == Read) || (state_q == Write);
  assign we_o    = (state_q == Write);
  assign addr_o  = req_q.addr;
  assign wdata_o = (req_q.op == OpWrite) ? req_q.data : alu_result_i;
  always_comb begin
    for (int i = 0; i < TL_DBW; i++) begin
      wmask_o[8*i +: 8] = {8{req_q.mask[i]}};
    end
  end

  assign alu_op_o      = req_q.op;
  assign alu_func_o    = req_q.func;
  assign alu_old_o     = old_q;
  assign alu_operand_o = req_q.data;

  // error requests answer in the accept cycle, all others from Respond
  always_comb begin
    rsp_valid_o     = (state_q == Respond);
    rsp_o.has_data  = (req_q.op != OpWrite);
    rsp_o.size      = req_q.size;
    rsp_o.source    = req_q.source;
    rsp_o.error     = err_q;
    rsp_o.data      = old_q;
    if (state_q == Idle && req_valid_i && req_i.op == OpError) begin
      rsp_valid_o    = 1'b1;
      rsp_o.has_data = 1'b0;
      rsp_o.size     = req_i.size;
      rsp_o.source   = req_i.source;
      rsp_o.error    = 1'b1;
      rsp_o.data     = '0;
    end
  end

  // SRAM side holds its request until granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o && !gnt_i |=> req_o && $stable({we_o, addr_o, wdata_o, wmask_o}));

  // top level only lets a request in while idle
  assert property (@(posedge clk_i) disable iff (!rst_ni) req_valid_i |-> idle_o);

endmodule

`default_nettype wire

//--- hdl/tluh_atomic_alu.sv
// ================================================
// tluh atomic ALU
// logical and arithmetic results for atomic RMW,
// from the old memory word and the bus operand
// ================================================
`timescale 1ns/100ps
`default_nettype none

module tluh_atomic_alu (
  input  tluh_pkg::req_op_e op_i,
  input  logic [2:0]        func_i,
  input  tluh_pkg::tl_data_t old_i,
  input  tluh_pkg::tl_data_t operand_i,
  output tluh_pkg::tl_data_t result_o
);

  import tluh_pkg::*;

  logic lt_signed;
  logic lt_unsigned;

  // compares are on full words, byte lanes are masked at the SRAM
  assign lt_signed   = $signed(old_i) < $signed(operand_i);
  assign lt_unsigned = old_i < operand_i;

  always_comb begin
    // unknown codes leave memory as it was
    result_o = old_i;
    if (op_i == OpLogic) begin
      case (func_i)
        LogicXor:  result_o = old_i ^ operand_i;
        LogicOr:   result_o = old_i | operand_i;
        LogicAnd:  result_o = old_i & operand_i;
        LogicSwap: result_o = operand_i;
        default:   result_o = old_i;
      endcase
    end else if (op_i == OpArith) begin
      case (func_i)
        ArithMin:  result_o = lt_signed ? old_i : operand_i;
        ArithMax:  result_o = lt_signed ? operand_i : old_i;
        ArithMinu: result_o = lt_unsigned ? old_i : operand_i;
        ArithMaxu: result_o = lt_unsigned ? operand_i : old_i;
        // carry out is dropped
        ArithAdd:  result_o = old_i + operand_i;
        default:   result_o = old_i;
      endcase
    end
  end

  // decode only lets defined function codes through to an atomic
  always_comb begin
    if (op_i inside {OpLogic, OpArith}) begin
      assert final ((op_i == OpLogic) ? (func_i <= LogicSwap) : (func_i <= ArithAdd))
        else $error("atomic function code out of range");
    end
  end

endmodule

`default_nettype wire

//--- hdl/tluh_req_decode.sv
// ================================================
// tluh request decode
// turns an A channel beat into a request for the
// SRAM sequencer, unsupported accesses become errors
// ================================================
`timescale 1ns/100ps
`default_nettype none

module tluh_req_decode (
  input  tluh_pkg::tl_a_t a_i,
  output tluh_pkg::req_t  req_o
);

  import tluh_pkg::*;

  req_op_e op;

  // opcode and param to operation
  always_comb begin
    case (a_i.opcode)
      Get: begin
        op = OpRead;
      end
      PutFullData, PutPartialData: begin
        op = OpWrite;
      end
      // params past the last defined code are rejected
      LogicalData: begin
        op = (a_i.param <= LogicSwap) ? OpLogic : OpError;
      end
      ArithmeticData: begin
        op = (a_i.param <= ArithAdd) ? OpArith : OpError;
      end
      default: begin
        op = OpError;
      end
    endcase
    // single beat only, no more than one bus word
    if (a_i.size > 2'd2) begin
      op = OpError;
    end
  end

  always_comb begin
    req_o.op     = op;
    req_o.func   = a_i.param;
    req_o.size   = a_i.size;
    req_o.source = a_i.source;
    // byte address to word address
    req_o.addr   = a_i.address[SRAM_AW+1:2];
    // full put writes the whole word whatever the mask says
    req_o.mask   = (a_i.opcode == PutFullData) ? '1 : a_i.mask;
    req_o.data   = a_i.data;
  end

endmodule

`default_nettype wire

//--- hdl/tluh_pkg.sv
// ================================================
// tluh package
// bus widths, TileLink opcode and param codes, the
// vector types and the structs passed between the
// decode, sequencer and response blocks
// ================================================
`default_nettype none

package tluh_pkg;

  // bus geometry
  localparam int TL_DW   = 32;
  localparam int TL_DBW  = TL_DW / 8;
  localparam int TL_AW   = 32;
  localparam int TL_AIW  = 4;
  localparam int TL_SZW  = 2;
  // word address into the SRAM, 4 KiB deep
  localparam int SRAM_AW = 10;

  // a channel opcodes
  localparam logic [2:0] PutFullData    = 3'd0;
  localparam logic [2:0] PutPartialData = 3'd1;
  localparam logic [2:0] ArithmeticData = 3'd2;
  localparam logic [2:0] LogicalData    = 3'd3;
  localparam logic [2:0] Get            = 3'd4;

  // d channel opcodes
  localparam logic [2:0] AccessAck      = 3'd0;
  localparam logic [2:0] AccessAckData  = 3'd1;

  // param field of LogicalData
  localparam logic [2:0] LogicXor  = 3'd0;
  localparam logic [2:0] LogicOr   = 3'd1;
  localparam logic [2:0] LogicAnd  = 3'd2;
  localparam logic [2:0] LogicSwap = 3'd3;

  // param field of ArithmeticData
  localparam logic [2:0] ArithMin  = 3'd0;
  localparam logic [2:0] ArithMax  = 3'd1;
  localparam logic [2:0] ArithMinu = 3'd2;
  localparam logic [2:0] ArithMaxu = 3'd3;
  localparam logic [2:0] ArithAdd  = 3'd4;

  typedef logic [TL_DW-1:0]   tl_data_t;
  typedef logic [TL_DBW-1:0]  tl_mask_t;
  typedef logic [TL_AW-1:0]   tl_addr_t;
  typedef logic [TL_AIW-1:0]  tl_source_t;
  // log2 of the byte count
  typedef logic [TL_SZW-1:0]  tl_size_t;
  typedef logic [SRAM_AW-1:0] sram_addr_t;

  // what the sequencer does with a request
  typedef enum logic [2:0] {
    OpRead,
    OpWrite,
    OpLogic,
    OpArith,
    OpError
  } req_op_e;

  typedef struct packed {
    logic [2:0] opcode;
    logic [2:0] param;
    tl_size_t   size;
    tl_source_t source;
    tl_addr_t   address;
    tl_mask_t   mask;
    tl_data_t   data;
  } tl_a_t;

  typedef struct packed {
    logic [2:0] opcode;
    tl_size_t   size;
    tl_source_t source;
    logic       error;
    tl_data_t   data;
  } tl_d_t;

  // decoded request, func carries the atomic param
  typedef struct packed {
    req_op_e    op;
    logic [2:0] func;
    tl_size_t   size;
    tl_source_t source;
    sram_addr_t addr;
    tl_mask_t   mask;
    tl_data_t   data;
  } req_t;

  typedef struct packed {
    logic       has_data;
    tl_size_t   size;
    tl_source_t source;
    logic       error;
    tl_data_t   data;
  } rsp_t;

endpackage

`default_nettype wire
